// ==== all.f ====
+incdir+design
design/cpu_types_pkg.sv
design/register_file.sv
design/alu.sv
design/control_unit.sv
design/request_unit.sv
design/datapath.sv
design/cpu_top.sv
bench/tb_memory.sv
bench/tb_cpu.sv

// ==== bench/tb_cpu.sv ====
// ******************************
// Testbench for the core. Loads a program and random data
// into the bus memory, predicts every store and checks
// each write cycle on the bus, then checks halt.
// ******************************

`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu;
    localparam int NUM_STORES     = 16;
    // 51 instruction words at 8 clocks each, with a margin of ten
    localparam int TIMEOUT_CYCLES = 10 * 51 * 8;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   halt;
    logic [1:0]             wait_states;
    cpu_types_pkg::wb_req_t wb_out;
    cpu_types_pkg::wb_rsp_t wb_in;
    logic [31:0]            lfsr_state = 32'd87373;
    cpu_types_pkg::word_t   d [0:7];
    cpu_types_pkg::word_t   exp_adr [0:NUM_STORES-1];
    cpu_types_pkg::word_t   exp_dat [0:NUM_STORES-1];
    int                     n_exp;
    int                     n_seen;
    int                     cycles;
    int                     load_idx;
    logic                   store_ack;

    cpu_top UUT (.CLK(clk), .arst_n(arst_n), .wb_out(wb_out), .wb_in(wb_in), .halt(halt));

    tb_memory mem (
        .clk(clk), .arst_n(arst_n), .wait_states(wait_states), .req(wb_out), .rsp(wb_in)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] rtype_word(logic [4:0] rs, logic [4:0] rt,
                                               logic [4:0] rd, logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype_word(logic [5:0] op, logic [4:0] rs,
                                               logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic put_instr(logic [31:0] w);
        mem.ram[load_idx] = w;
        load_idx++;
    endtask

    // store k of rt to 0x300 plus 4k, with the value the model predicts
    task automatic store_out(logic [4:0] rt, logic [31:0] value);
        put_instr(itype_word(6'h2B, 5'd2, rt, 16'(n_exp * 4)));
        exp_adr[n_exp] = 32'h300 + 32'(n_exp * 4);
        exp_dat[n_exp] = value;
        n_exp++;
    endtask

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic value_error(string name, logic [31:0] expected, logic [31:0] actual);
        $display("ERR %s expected %h actual %h (store %0d)", name, expected, actual, n_seen);
        fail_run("store mismatch");
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            mem.ram[i] = 32'hA5A5_0000 ^ 32'(i * 4);
        end
        for (int i = 0; i < 8; i++) begin
            d[i] = take_bits(32);
            mem.ram[128 + i] = d[i];
        end
        load_idx = 0;
        n_exp    = 0;
        put_instr(itype_word(6'h0D, 5'd0, 5'd1, 16'h0200));
        put_instr(itype_word(6'h0D, 5'd0, 5'd2, 16'h0300));
        for (int i = 0; i < 8; i++) begin
            put_instr(itype_word(6'h23, 5'd1, 5'(8 + i), 16'(i * 4)));
        end
        put_instr(rtype_word(5'd8, 5'd9, 5'd16, 6'h21));
        store_out(5'd16, d[0] + d[1]);
        put_instr(rtype_word(5'd10, 5'd11, 5'd16, 6'h23));
        store_out(5'd16, d[2] - d[3]);
        put_instr(rtype_word(5'd12, 5'd13, 5'd16, 6'h24));
        store_out(5'd16, d[4] & d[5]);
        put_instr(rtype_word(5'd14, 5'd15, 5'd16, 6'h25));
        store_out(5'd16, d[6] | d[7]);
        put_instr(rtype_word(5'd8, 5'd15, 5'd16, 6'h26));
        store_out(5'd16, d[0] ^ d[7]);
        put_instr(rtype_word(5'd9, 5'd10, 5'd16, 6'h2A));
        store_out(5'd16, ($signed(d[1]) < $signed(d[2])) ? 32'd1 : 32'd0);
        put_instr(itype_word(6'h09, 5'd11, 5'd16, 16'h8123));
        store_out(5'd16, d[3] + 32'hFFFF_8123);
        put_instr(itype_word(6'h0C, 5'd12, 5'd16, 16'hF0F0));
        store_out(5'd16, d[4] & 32'h0000_F0F0);
        put_instr(itype_word(6'h0D, 5'd13, 5'd16, 16'h8001));
        store_out(5'd16, d[5] | 32'h0000_8001);
        put_instr(itype_word(6'h0F, 5'd0, 5'd16, 16'hBEEF));
        store_out(5'd16, 32'hBEEF_0000);
        // store, reload into r17, store again
        store_out(5'd14, d[6]);
        put_instr(itype_word(6'h23, 5'd2, 5'd17, 16'd40));
        store_out(5'd17, d[6]);
        // r18 holds the marker that skipped stores would write
        put_instr(itype_word(6'h0D, 5'd0, 5'd18, 16'hDEAD));
        put_instr(itype_word(6'h04, 5'd8, 5'd8, 16'd1));
        put_instr(itype_word(6'h2B, 5'd2, 5'd18, 16'd48));
        put_instr(itype_word(6'h05, 5'd0, 5'd18, 16'd1));
        put_instr(itype_word(6'h2B, 5'd2, 5'd18, 16'd48));
        put_instr(itype_word(6'h04, 5'd0, 5'd18, 16'd1));
        store_out(5'd8, d[0]);
        put_instr(itype_word(6'h05, 5'd8, 5'd8, 16'd1));
        store_out(5'd9, d[1]);
        // word 42 jumps over a marker store to the jal at 44
        put_instr({6'h02, 26'd44});
        put_instr(itype_word(6'h2B, 5'd2, 5'd18, 16'd56));
        put_instr({6'h03, 26'd46});
        put_instr({6'h02, 26'd48});
        store_out(5'd31, 32'd45 * 4);
        put_instr(rtype_word(5'd31, 5'd0, 5'd0, 6'h08));
        put_instr(itype_word(6'h09, 5'd8, 5'd0, 16'd5));
        store_out(5'd0, 32'd0);
        put_instr(`CPU_HALT_WORD);
    endtask

    assign store_ack = arst_n && wb_out.cyc && wb_out.stb && wb_out.we && wb_in.ack;

    always @(posedge clk) begin
        if (store_ack) begin
            assert (n_seen < NUM_STORES) else fail_run("more stores than the program makes");
        end
    end

    always @(posedge clk) begin
        if (store_ack && n_seen < NUM_STORES) begin
            assert (wb_out.adr == exp_adr[n_seen])
                else value_error("adr", exp_adr[n_seen], wb_out.adr);
        end
    end

    always @(posedge clk) begin
        if (store_ack && n_seen < NUM_STORES) begin
            assert (wb_out.dat_w == exp_dat[n_seen])
                else value_error("dat_w", exp_dat[n_seen], wb_out.dat_w);
        end
    end

    always @(posedge clk) begin
        if (halt) begin
            assert (!wb_out.cyc) else fail_run("bus cycle started after halt");
        end
    end

    always @(posedge clk) begin
        if (store_ack) n_seen <= n_seen + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) fail_run("timeout, the core never halted");
    end

    // fresh wait-state count each falling edge
    always @(negedge clk) begin
        wait_states <= 2'(take_bits(2));
    end

    initial begin
        arst_n      = 1'b0;
        wait_states = 2'd0;
        n_seen      = 0;
        cycles      = 0;
        load_program();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        wait (halt);
        repeat (20) @(posedge clk);
        if (n_seen == NUM_STORES) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("only %0d of %0d stores seen before halt", n_seen, NUM_STORES);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

// ==== bench/tb_memory.sv ====
// ******************************
// Wishbone classic slave memory for the core testbench.
// Responds on the falling edge after 0 to 3 wait states
// taken from wait_states when a cycle starts.
// ******************************

`timescale 1ns/1ps

module tb_memory (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [1:0]             wait_states,
    input  cpu_types_pkg::wb_req_t req,
    output cpu_types_pkg::wb_rsp_t rsp
);
    // 256 words, byte addresses 0x000 to 0x3FC
    logic [31:0]          ram [0:255];
    logic                 ack;
    logic                 busy;
    logic [1:0]           wait_left;
    cpu_types_pkg::word_t dat_r;

    always @(negedge clk, negedge arst_n) begin
        if (!arst_n) begin
            ack   <= 1'b0;
            busy  <= 1'b0;
            dat_r <= '0;
        end else if (ack) begin
            // master drops stb on the edge that saw ack
            ack  <= 1'b0;
            busy <= 1'b0;
        end else if (req.cyc && req.stb) begin
            if ((!busy && wait_states == 2'd0) || (busy && wait_left == 2'd1)) begin
                ack   <= 1'b1;
                dat_r <= ram[req.adr[9:2]];
                if (req.we) begin
                    ram[req.adr[9:2]] = req.dat_w;
                end
            end else if (!busy) begin
                busy      <= 1'b1;
                wait_left <= wait_states;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    assign rsp.ack   = ack;
    assign rsp.dat_r = dat_r;

endmodule

// ==== design/alu.sv ====
// ******************************
// Combinational ALU for the core. Handles add, subtract,
// the logic ops, signed slt and lui; the zero flag feeds
// the branch compare.
// ******************************

`timescale 1ns/1ps

module alu (
    input  cpu_types_pkg::aluop_t op,
    input  cpu_types_pkg::word_t  port_a,
    input  cpu_types_pkg::word_t  port_b,
    output cpu_types_pkg::word_t  out_port,
    output logic                  zero
);
    always_comb begin
        case (op)
            cpu_types_pkg::alu_add: out_port = port_a + port_b;
            cpu_types_pkg::alu_sub: out_port = port_a - port_b;
            cpu_types_pkg::alu_and: out_port = port_a & port_b;
            cpu_types_pkg::alu_or:  out_port = port_a | port_b;
            cpu_types_pkg::alu_xor: out_port = port_a ^ port_b;
            cpu_types_pkg::alu_slt: begin
                // signed compare, result in bit zero
                out_port = {31'd0, $signed(port_a) < $signed(port_b)};
            end
            cpu_types_pkg::alu_lui: out_port = port_b << 16;
            default:                out_port = '0;
        endcase
    end

    // beq and bne look at this after a subtract
    assign zero = (out_port == '0);

endmodule

// ==== design/control_unit.sv ====
// ******************************
// Instruction decoder. Purely combinational, it turns
// opcode and funct into datapath selects, the ALU op,
// the memory request kind and the halt flag.
// ******************************

`timescale 1ns/1ps
`include "cpu_consts.svh"

module control_unit (
    input  cpu_types_pkg::word_t  instr,
    output cpu_types_pkg::aluop_t alu_op,
    output logic                  reg_dst,
    output logic                  alu_src,
    output logic                  ext_sign,
    output logic                  mem_to_reg,
    output logic                  reg_wen,
    output logic                  dmemren,
    output logic                  dmemwen,
    output logic                  branch,
    output logic                  branch_ne,
    output logic                  jump,
    output logic                  jump_reg,
    output logic                  link,
    output logic                  halt_op
);
    cpu_types_pkg::r_t r_fmt;

    assign r_fmt = instr;

    always_comb begin
        // no-op unless something below says otherwise
        alu_op     = cpu_types_pkg::alu_add;
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        ext_sign   = 1'b0;
        mem_to_reg = 1'b0;
        reg_wen    = 1'b0;
        dmemren    = 1'b0;
        dmemwen    = 1'b0;
        branch     = 1'b0;
        branch_ne  = 1'b0;
        jump       = 1'b0;
        jump_reg   = 1'b0;
        link       = 1'b0;
        halt_op    = (instr == `CPU_HALT_WORD);

        case (r_fmt.opcode)
            cpu_types_pkg::op_rtype: begin
                reg_dst = 1'b1;
                reg_wen = 1'b1;
                case (r_fmt.funct)
                    cpu_types_pkg::fn_addu: alu_op = cpu_types_pkg::alu_add;
                    cpu_types_pkg::fn_subu: alu_op = cpu_types_pkg::alu_sub;
                    cpu_types_pkg::fn_and:  alu_op = cpu_types_pkg::alu_and;
                    cpu_types_pkg::fn_or:   alu_op = cpu_types_pkg::alu_or;
                    cpu_types_pkg::fn_xor:  alu_op = cpu_types_pkg::alu_xor;
                    cpu_types_pkg::fn_slt:  alu_op = cpu_types_pkg::alu_slt;
                    cpu_types_pkg::fn_jr: begin
                        jump_reg = 1'b1;
                        reg_wen  = 1'b0;
                    end
                    default: reg_wen = 1'b0;
                endcase
            end
            cpu_types_pkg::op_addiu: begin
                alu_src  = 1'b1;
                ext_sign = 1'b1;
                reg_wen  = 1'b1;
            end
            cpu_types_pkg::op_andi: begin
                alu_op  = cpu_types_pkg::alu_and;
                alu_src = 1'b1;
                reg_wen = 1'b1;
            end
            cpu_types_pkg::op_ori: begin
                alu_op  = cpu_types_pkg::alu_or;
                alu_src = 1'b1;
                reg_wen = 1'b1;
            end
            cpu_types_pkg::op_lui: begin
                alu_op  = cpu_types_pkg::alu_lui;
                alu_src = 1'b1;
                reg_wen = 1'b1;
            end
            cpu_types_pkg::op_lw: begin
                alu_src    = 1'b1;
                ext_sign   = 1'b1;
                mem_to_reg = 1'b1;
                reg_wen    = 1'b1;
                dmemren    = 1'b1;
            end
            cpu_types_pkg::op_sw: begin
                alu_src  = 1'b1;
                ext_sign = 1'b1;
                dmemwen  = 1'b1;
            end
            cpu_types_pkg::op_beq: begin
                alu_op   = cpu_types_pkg::alu_sub;
                ext_sign = 1'b1;
                branch   = 1'b1;
            end
            cpu_types_pkg::op_bne: begin
                alu_op    = cpu_types_pkg::alu_sub;
                ext_sign  = 1'b1;
                branch_ne = 1'b1;
            end
            cpu_types_pkg::op_j:   jump = 1'b1;
            cpu_types_pkg::op_jal: begin
                jump    = 1'b1;
                link    = 1'b1;
                reg_wen = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== design/cpu_consts.svh ====
// ******************************
// Core-wide constants for the single-cycle MIPS subset.
// Include this file wherever the reset PC, the halt
// word, the link register or the register count is needed.
// ******************************

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first fetch address after reset
`define CPU_PC_INIT 32'h0000_0000

// all-ones instruction stops the core
`define CPU_HALT_WORD 32'hFFFF_FFFF

// jal writes its return address here
`define CPU_LINK_REG 5'd31

`define CPU_NUM_REGS 32

`endif

// ==== design/cpu_top.sv ====
// ******************************
// Core top level. Joins the datapath to the Wishbone
// request unit and brings the bus and halt out.
// ******************************

`timescale 1ns/1ps

module cpu_top (
    input  logic                   CLK,
    input  logic                   arst_n,
    output cpu_types_pkg::wb_req_t wb_out,
    input  cpu_types_pkg::wb_rsp_t wb_in,
    output logic                   halt
);
    cpu_types_pkg::dp_req_t dpreq;
    cpu_types_pkg::dp_rsp_t dprsp;

    datapath dp (
        .CLK(CLK), .arst_n(arst_n), .dprsp(dprsp), .dpreq(dpreq), .halt(halt)
    );

    request_unit ru (
        .CLK(CLK), .arst_n(arst_n), .halt(halt), .dpreq(dpreq), .dprsp(dprsp),
        .wb_out(wb_out), .wb_in(wb_in)
    );

endmodule

// ==== design/cpu_types_pkg.sv ====
// ******************************
// Shared types for the core: words, instruction fields,
// opcode and ALU encodings, and the structs that carry
// the Wishbone bus and the datapath requests.
// ******************************

package cpu_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regsel_t;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addiu = 6'h09,
        op_andi  = 6'h0C,
        op_ori   = 6'h0D,
        op_lui   = 6'h0F,
        op_lw    = 6'h23,
        op_sw    = 6'h2B
    } opcode_t;

    typedef enum logic [5:0] {
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2A
    } funct_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_lui
    } aluop_t;

    typedef struct packed {
        opcode_t     opcode;
        regsel_t     rs;
        regsel_t     rt;
        regsel_t     rd;
        logic [4:0]  shamt;
        funct_t      funct;
    } r_t;

    typedef struct packed {
        opcode_t     opcode;
        regsel_t     rs;
        regsel_t     rt;
        logic [15:0] imm;
    } i_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] addr;
    } j_t;

    // master side of the Wishbone bus
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat_w;
    } wb_req_t;

    // slave side of the Wishbone bus
    typedef struct packed {
        logic  ack;
        word_t dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic  dmemren;
        logic  dmemwen;
        word_t dmemaddr;
        word_t dmemstore;
        word_t imemaddr;
    } dp_req_t;

    typedef struct packed {
        logic  ihit;
        word_t imemload;
        word_t dmemload;
    } dp_rsp_t;

endpackage

// ==== design/datapath.sv ====
// ******************************
// Single-cycle datapath with PC, extender, next-PC and
// write-back muxes and the halt latch. State advances
// only on ihit from the request unit.
// ******************************

`timescale 1ns/1ps
`include "cpu_consts.svh"

module datapath (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  cpu_types_pkg::dp_rsp_t dprsp,
    output cpu_types_pkg::dp_req_t dpreq,
    output logic                   halt
);
    cpu_types_pkg::r_t     r_fmt;
    cpu_types_pkg::i_t     i_fmt;
    cpu_types_pkg::j_t     j_fmt;
    cpu_types_pkg::aluop_t alu_op;
    cpu_types_pkg::word_t  pc, pc_plus4, next_pc, ext_imm, branch_target, jump_target;
    cpu_types_pkg::word_t  rdat1, rdat2, wdat, alu_b, alu_out;
    cpu_types_pkg::regsel_t wsel;
    logic reg_dst, alu_src, ext_sign, mem_to_reg, reg_wen, dmemren, dmemwen;
    logic branch, branch_ne, jump, jump_reg, link, halt_op, alu_zero, take_branch;

    assign r_fmt = dprsp.imemload;
    assign i_fmt = dprsp.imemload;
    assign j_fmt = dprsp.imemload;

    control_unit cu (
        .instr(dprsp.imemload), .alu_op(alu_op), .reg_dst(reg_dst), .alu_src(alu_src),
        .ext_sign(ext_sign), .mem_to_reg(mem_to_reg), .reg_wen(reg_wen),
        .dmemren(dmemren), .dmemwen(dmemwen), .branch(branch), .branch_ne(branch_ne),
        .jump(jump), .jump_reg(jump_reg), .link(link), .halt_op(halt_op)
    );

    // writes commit together with the PC on ihit
    register_file rf (
        .CLK(CLK), .arst_n(arst_n), .wen(reg_wen && dprsp.ihit), .wsel(wsel),
        .wdat(wdat), .rsel1(r_fmt.rs), .rsel2(r_fmt.rt), .rdat1(rdat1), .rdat2(rdat2)
    );

    alu alu_i (
        .op(alu_op), .port_a(rdat1), .port_b(alu_b), .out_port(alu_out), .zero(alu_zero)
    );

    // sign or zero extension of the immediate
    assign ext_imm = ext_sign ? {{16{i_fmt.imm[15]}}, i_fmt.imm} : {16'd0, i_fmt.imm};
    assign alu_b   = alu_src ? ext_imm : rdat2;

    assign wsel = link ? `CPU_LINK_REG : (reg_dst ? r_fmt.rd : r_fmt.rt);
    assign wdat = link ? pc_plus4 : (mem_to_reg ? dprsp.dmemload : alu_out);

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + (ext_imm << 2);
    assign jump_target   = {pc_plus4[31:28], j_fmt.addr, 2'b00};
    assign take_branch   = (branch && alu_zero) || (branch_ne && !alu_zero);

    always_comb begin
        if (jump_reg)         next_pc = rdat1;
        else if (jump)        next_pc = jump_target;
        else if (take_branch) next_pc = branch_target;
        else                  next_pc = pc_plus4;
    end

    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n) begin
            pc   <= `CPU_PC_INIT;
            halt <= 1'b0;
        end else if (dprsp.ihit) begin
            pc <= next_pc;
            if (halt_op) halt <= 1'b1;
        end
    end

    assign dpreq.dmemren   = dmemren;
    assign dpreq.dmemwen   = dmemwen;
    assign dpreq.dmemaddr  = alu_out;
    assign dpreq.dmemstore = rdat2;
    assign dpreq.imemaddr  = pc;

    // no ihit from the request unit means no PC move
    a_pc_on_ihit: assert property (@(posedge CLK) disable iff (!arst_n)
        !dprsp.ihit |=> $stable(pc));

endmodule

// ==== design/register_file.sv ====
// ******************************
// General purpose register file. Two combinational read
// ports, one write port on the clock edge; register zero
// always reads as zero.
// ******************************

`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  logic                   wen,
    input  cpu_types_pkg::regsel_t wsel,
    input  cpu_types_pkg::word_t   wdat,
    input  cpu_types_pkg::regsel_t rsel1,
    input  cpu_types_pkg::regsel_t rsel2,
    output cpu_types_pkg::word_t   rdat1,
    output cpu_types_pkg::word_t   rdat2
);
    // register zero has no storage
    cpu_types_pkg::word_t regs [1:`CPU_NUM_REGS-1];

    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdat;
        end
    end

    assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
    assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

    // holds even right after a write aimed at register zero
    a_zero_reg: assert property (@(posedge CLK) disable iff (!arst_n)
        rsel1 == '0 |-> rdat1 == '0);

endmodule

// ==== design/request_unit.sv ====
// ******************************
// Wishbone classic master. Per instruction it fetches,
// optionally runs one load or store, then pulses ihit
// for one clock. Starts nothing once halt is set.
// ******************************

`timescale 1ns/1ps

module request_unit (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  logic                   halt,
    input  cpu_types_pkg::dp_req_t dpreq,
    output cpu_types_pkg::dp_rsp_t dprsp,
    output cpu_types_pkg::wb_req_t wb_out,
    input  cpu_types_pkg::wb_rsp_t wb_in
);
    typedef enum logic [1:0] {st_idle, st_fetch, st_data, st_done} state_t;

    state_t               state, next_state;
    logic                 ihit, data_done, need_data, finish, bus_active;
    cpu_types_pkg::word_t imemload, dmemload;

    // decode is valid here, imemload latched at fetch ack
    assign need_data = (dpreq.dmemren || dpreq.dmemwen) && !data_done;
    assign finish    = (state == st_done) && !need_data;

    always_comb begin
        next_state = state;
        case (state)
            // ihit high means the PC is updating this edge
            st_idle:  if (!halt && !ihit) next_state = st_fetch;
            st_fetch: if (wb_in.ack) next_state = st_done;
            st_data:  if (wb_in.ack) next_state = st_done;
            st_done:  next_state = need_data ? st_data : st_idle;
            default:  next_state = st_idle;
        endcase
    end

    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            ihit      <= 1'b0;
            data_done <= 1'b0;
        end else begin
            state <= next_state;
            ihit  <= finish;
            if (state == st_data && wb_in.ack) begin
                data_done <= 1'b1;
            end else if (finish) begin
                data_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == st_fetch && wb_in.ack) imemload <= wb_in.dat_r;
        if (state == st_data && wb_in.ack && !dpreq.dmemwen) dmemload <= wb_in.dat_r;
    end

    assign bus_active   = (state == st_fetch) || (state == st_data);
    assign wb_out.cyc   = bus_active;
    assign wb_out.stb   = bus_active;
    assign wb_out.we    = (state == st_data) && dpreq.dmemwen;
    assign wb_out.adr   = (state == st_data) ? dpreq.dmemaddr : dpreq.imemaddr;
    assign wb_out.dat_w = dpreq.dmemstore;

    assign dprsp.ihit     = ihit;
    assign dprsp.imemload = imemload;
    assign dprsp.dmemload = dmemload;

    a_stb_cyc: assert property (@(posedge CLK) disable iff (!arst_n)
        wb_out.stb |-> wb_out.cyc);

    // request held until the slave answers
    a_hold: assert property (@(posedge CLK) disable iff (!arst_n)
        wb_out.stb && !wb_in.ack |=>
            wb_out.stb && $stable(wb_out.adr) && $stable(wb_out.we));

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_cpu -o tb_cpu_sim &&
./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
